// File: sources.f
hdl/multiFifoPkg.sv
hdl/flopRam.sv
hdl/freeList.sv
hdl/creditReturn.sv
hdl/listCtrl.sv
hdl/popStager.sv
hdl/sharedMultiFifo.sv
testbench/multiFifoChecker.sv
testbench/multiFifoTb.sv

// File: run.sh
#!/bin/sh
# Builds the shared multi-FIFO testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module multiFifoTb -f sources.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/VmultiFifoTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "=== PASS ==="; then
  exit 0
fi
exit 1

// File: testbench/multiFifoTb.sv
// Shared multi-FIFO testbench
// Drives the push side as a credit-holding sender and the pop ports with
// fixed or random ready patterns. Runs the reset, ordering, interleaving,
// back-pressure, credit stall and random soak tests and reports the result.
module multiFifoTb
  import multiFifoPkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  logic                clk = 1'b0;
  logic                rst;
  logic                pushSenderInReset;
  logic                pushReceiverInReset;
  logic                pushCreditStall;
  logic                pushCredit;
  logic                pushValid;
  dataT                pushData;
  fifoIdT              pushFifoId;
  logic [NumFifos-1:0] popValid;
  logic [NumFifos-1:0] popReady;
  dataT [NumFifos-1:0] popData;
  logic [NumFifos-1:0] popEmpty;

  // Credits the sender holds and may spend on pushes
  int          heldCredits = 0;
  bit          timedOut = 1'b0;
  logic [31:0] lcgState = 32'h7527b4aa;

  always #2 clk = ~clk;

  sharedMultiFifo sharedMultiFifo_inst (
    .clk, .rst, .pushSenderInReset, .pushReceiverInReset, .pushCreditStall, .pushCredit,
    .pushValid, .pushData, .pushFifoId, .popValid, .popReady, .popData, .popEmpty
  );

  multiFifoChecker checker_inst (
    .clk, .rst, .pushSenderInReset, .pushCreditStall, .pushCredit, .pushValid, .pushData,
    .pushFifoId, .popValid, .popReady, .popData
  );

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // Upper bits of the LCG are the most random ones
  function automatic dataT randData();
    return dataT'(lcgNext() >> 16);
  endfunction

  function automatic fifoIdT randFifo();
    return fifoIdT'(lcgNext() >> 30);
  endfunction

  // A credit seen mid-cycle is handed over at the next edge
  task automatic tick();
    @(negedge clk);
    if (!rst && !pushSenderInReset && pushCredit) begin
      heldCredits++;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) tick();
  endtask

  task automatic giveUp(input string why);
    checker_inst.noteError({"timed out waiting until ", why});
    timedOut = 1'b1;
  endtask

  task automatic waitCredits(input int wanted);
    int cycles;
    cycles = 0;
    while (heldCredits < wanted && !timedOut) begin
      if (cycles == 200) begin
        giveUp("enough credits were returned");
      end else begin
        tick();
      end
      cycles++;
    end
  endtask

  task automatic drainAll();
    int cycles;
    cycles = 0;
    popReady = '1;
    while (popEmpty != '1 && !timedOut) begin
      if (cycles == 200) begin
        giveUp("all FIFOs were drained");
      end else begin
        tick();
      end
      cycles++;
    end
    checker_inst.expectEq("words left in reference queues", 0, checker_inst.pending());
  endtask

  task automatic settleCredits();
    waitCredits(Depth);
    if (timedOut) return;
    idle(10);
    checker_inst.expectEq("credits held", Depth, heldCredits);
    checker_inst.checkCreditBalance();
  endtask

  task automatic pushOne(input fifoIdT id, input dataT value);
    waitCredits(1);
    if (timedOut) return;
    pushValid = 1'b1;
    pushFifoId = id;
    pushData = value;
    heldCredits--;
    tick();
    pushValid = 1'b0;
  endtask

  // Pushes only when a credit is held, otherwise idles for the cycle
  task automatic tryPush(input fifoIdT id, input dataT value, input bit wanted);
    pushValid = wanted && heldCredits > 0;
    pushFifoId = id;
    pushData = value;
    if (pushValid) heldCredits--;
    tick();
    pushValid = 1'b0;
  endtask

  task automatic applyReset(input bit viaSender);
    rst = !viaSender;
    pushSenderInReset = viaSender;
    pushValid = 1'b0;
    pushCreditStall = 1'b0;
    popReady = '0;
    heldCredits = 0;
    tick();
    checker_inst.expectEq("popValid in reset", 0, int'(popValid));
    checker_inst.expectEq("popEmpty in reset", 'hF, int'(popEmpty));
    checker_inst.expectEq("receiver in reset", 1, int'(pushReceiverInReset));
    tick();
    rst = 1'b0;
    pushSenderInReset = 1'b0;
  endtask

  // Exactly Depth credits come back after reset and then the line goes quiet
  task automatic resetTest(input bit viaSender);
    applyReset(viaSender);
    waitCredits(Depth);
    if (timedOut) return;
    idle(20);
    checker_inst.expectEq("credits after reset", Depth, heldCredits);
    checker_inst.expectEq("popValid after reset", 0, int'(popValid));
    checker_inst.expectEq("popEmpty after reset", 'hF, int'(popEmpty));
    checker_inst.checkCreditBalance();
  endtask

  task automatic orderTest();
    popReady = '0;
    for (int i = 0; i < 8; i++) begin
      pushOne(fifoIdT'(2), randData());
      if (timedOut) return;
      checker_inst.expectEq("popEmpty of other FIFOs", 'hB, int'(popEmpty & 4'hB));
    end
    drainAll();
    settleCredits();
  endtask

  task automatic interleaveTest();
    popReady = '1;
    repeat (150) tryPush(randFifo(), randData(), 1'b1);
    drainAll();
    settleCredits();
  endtask

  // FIFO 1 and 3 hold one staged word each, then FIFO 0 takes every entry
  task automatic backPressureTest();
    popReady = '0;
    pushOne(fifoIdT'(1), randData());
    pushOne(fifoIdT'(3), randData());
    for (int i = 0; i <= Depth; i++) begin
      pushOne(fifoIdT'(0), randData());
    end
    if (timedOut) return;
    idle(20);
    checker_inst.expectEq("credits with FIFO 0 full", 0, heldCredits);
    popReady = 4'b1010;
    idle(10);
    checker_inst.expectEq("staged FIFOs popped", 0, int'(popValid & 4'b1010));
    checker_inst.expectEq("credits after staged pops", 0, heldCredits);
    drainAll();
    settleCredits();
  endtask

  task automatic stallTest();
    popReady = '1;
    pushCreditStall = 1'b1;
    for (int i = 0; i < 8; i++) begin
      pushOne(randFifo(), randData());
    end
    drainAll();
    if (timedOut) return;
    idle(10);
    checker_inst.expectEq("credits during stall", Depth - 8, heldCredits);
    pushCreditStall = 1'b0;
    settleCredits();
  endtask

  task automatic soakTest();
    for (int i = 0; i < 2000; i++) begin
      popReady = 4'(lcgNext() >> 28);
      tryPush(randFifo(), randData(), (lcgNext() >> 30) != 0);
    end
    drainAll();
    settleCredits();
    checker_inst.expectEq("popEmpty after soak", 'hF, int'(popEmpty));
  endtask

  task automatic runTest(input int which, input string name);
    if (!timedOut) begin
      checker_inst.beginTest(name);
      case (which)
        1: begin
          resetTest(1'b0);
          if (!timedOut) resetTest(1'b1);
        end
        2: orderTest();
        3: interleaveTest();
        4: backPressureTest();
        5: stallTest();
        default: soakTest();
      endcase
      checker_inst.endTest();
    end
  endtask

  initial begin
    rst = 1'b1;
    pushSenderInReset = 1'b0;
    pushCreditStall = 1'b0;
    pushValid = 1'b0;
    pushData = '0;
    pushFifoId = '0;
    popReady = '0;
    runTest(1, "reset state");
    runTest(2, "single FIFO order");
    runTest(3, "interleaving");
    runTest(4, "back-pressure");
    runTest(5, "credit stall");
    runTest(6, "random soak");
    $display("Tests run: %0d, errors: %0d, timed out: %0d",
             checker_inst.testCount, checker_inst.errorCount, timedOut);
    if (checker_inst.errorCount == 0 && !timedOut) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule : multiFifoTb

// File: testbench/multiFifoChecker.sv
// Multi-FIFO checker
// Watches the ports of the shared multi-FIFO. Keeps one reference queue per
// logical FIFO, compares every pop with the front of its queue, counts pushes
// and returned credits since the last reset, and keeps the per-test tallies.
module multiFifoChecker
  import multiFifoPkg::*;
(
  input logic                clk,
  input logic                rst,
  input logic                pushSenderInReset,
  input logic                pushCreditStall,
  input logic                pushCredit,
  input logic                pushValid,
  input dataT                pushData,
  input fifoIdT              pushFifoId,
  input logic [NumFifos-1:0] popValid,
  input logic [NumFifos-1:0] popReady,
  input dataT [NumFifos-1:0] popData
);
  timeunit 1ns;
  timeprecision 100ps;

  // Reference model state, one queue of pushed words per logical FIFO
  dataT  refQ [NumFifos][$];
  dataT  expectedData;
  bit    found;
  int    pushCount = 0;
  int    creditCount = 0;
  int    errorCount = 0;
  int    testErrors = 0;
  int    testCount = 0;
  string curTest = "startup";

  // Expected word for a pop is the oldest push to that FIFO not yet popped
  function automatic bit refPop(input int id, output dataT expected);
    expected = '0;
    if (refQ[id].size() == 0) begin
      return 1'b0;
    end
    expected = refQ[id].pop_front();
    return 1'b1;
  endfunction

  function automatic int pending();
    int total;
    total = 0;
    for (int i = 0; i < NumFifos; i++) begin
      total += refQ[i].size();
    end
    return total;
  endfunction

  task automatic noteError(input string what);
    $display("Error in %s: %s", curTest, what);
    testErrors++;
    errorCount++;
  endtask

  task automatic expectEq(input string what, input int expected, input int actual);
    if (expected != actual) begin
      $display("Fail %s (%s): expected %0h, actual %0h", curTest, what, expected, actual);
      testErrors++;
      errorCount++;
    end
  endtask

  task automatic beginTest(input string name);
    curTest = name;
    testErrors = 0;
  endtask

  task automatic endTest();
    testCount++;
    $display("Test %s finished with %0d errors", curTest, testErrors);
  endtask

  // Every pushed entry that has been freed owes one credit on top of the
  // Depth credits handed out after reset
  task automatic checkCreditBalance();
    expectEq("credits returned", Depth + pushCount, creditCount);
  endtask

  // Mid-cycle sampling sees the handshakes that complete at the next edge
  always @(negedge clk) begin
    if (rst || pushSenderInReset) begin
      for (int i = 0; i < NumFifos; i++) begin
        refQ[i].delete();
      end
      pushCount = 0;
      creditCount = 0;
    end else begin
      // Pops first, a word is never popped in the cycle it is pushed
      for (int i = 0; i < NumFifos; i++) begin
        if (popValid[i] && popReady[i]) begin
          found = refPop(i, expectedData);
          if (!found) begin
            noteError($sformatf("FIFO %0d popped a word that was never pushed", i));
          end else begin
            expectEq($sformatf("FIFO %0d pop data", i), int'(expectedData), int'(popData[i]));
          end
        end
      end
      if (pushValid) begin
        refQ[pushFifoId].push_back(pushData);
        pushCount++;
      end
      if (pushCredit) begin
        creditCount++;
        if (pushCreditStall) begin
          noteError("a credit was returned while the stall was high");
        end
      end
    end
  end

endmodule : multiFifoChecker

// File: hdl/sharedMultiFifo.sv
// Shared dynamic multi-FIFO
// Four logical FIFOs share one flop store whose entries are handed out
// on demand. Pushes use a valid/credit interface with a FIFO index, and
// each logical FIFO pops through its own ready/valid port.
module sharedMultiFifo
  import multiFifoPkg::*;
(
  input  logic                clk,
  input  logic                rst,

  // Push side
  input  logic                pushSenderInReset,
  output logic                pushReceiverInReset,
  input  logic                pushCreditStall,
  output logic                pushCredit,
  input  logic                pushValid,
  input  dataT                pushData,
  input  fifoIdT              pushFifoId,

  // Pop side
  output logic [NumFifos-1:0] popValid,
  input  logic [NumFifos-1:0] popReady,
  output dataT [NumFifos-1:0] popData,
  output logic [NumFifos-1:0] popEmpty
);

  // Either side in reset resets the whole receiver
  logic eitherRst;
  assign eitherRst = rst || pushSenderInReset;

  // Internal connections
  logic                allocValid;
  addrT                allocAddr;
  logic                deallocValid;
  addrT                deallocAddr;
  logic [NumFifos-1:0] listNonEmpty;
  addrT [NumFifos-1:0] listHead;
  logic                removeValid;
  fifoIdT              removeFifoId;
  addrT                dataRdAddr;
  dataT                dataRdData;
  logic                ptrWrValid;
  addrT                ptrWrAddr;
  addrT                ptrWrData;
  addrT                ptrRdAddr;
  addrT                ptrRdData;

  // Every accepted push takes one store entry
  assign allocValid = pushValid;

  // Payload store, written at the address taken from the free list
  flopRam #(.payloadT(dataT)) dataRam_inst (
    .clk, .wrValid(pushValid), .wrAddr(allocAddr), .wrData(pushData),
    .rdAddr(dataRdAddr), .rdData(dataRdData)
  );

  // Link store, one next-entry address per store entry
  flopRam #(.payloadT(addrT)) ptrRam_inst (
    .clk, .wrValid(ptrWrValid), .wrAddr(ptrWrAddr), .wrData(ptrWrData),
    .rdAddr(ptrRdAddr), .rdData(ptrRdData)
  );

  freeList freeList_inst (
    .clk, .rst(eitherRst), .allocValid, .allocAddr, .deallocValid, .deallocAddr
  );

  creditReturn creditReturn_inst (
    .clk, .rst(eitherRst), .deallocValid, .pushCreditStall, .pushCredit,
    .pushReceiverInReset
  );

  listCtrl listCtrl_inst (
    .clk, .rst(eitherRst), .pushValid, .pushFifoId, .allocAddr, .removeValid,
    .removeFifoId, .listNonEmpty, .listHead, .ptrWrValid, .ptrWrAddr, .ptrWrData,
    .ptrRdAddr, .ptrRdData
  );

  popStager popStager_inst (
    .clk, .rst(eitherRst), .listNonEmpty, .listHead, .removeValid, .removeFifoId,
    .dataRdAddr, .dataRdData, .deallocValid, .deallocAddr, .popValid, .popReady,
    .popData, .popEmpty
  );

endmodule : sharedMultiFifo

// File: hdl/popStager.sv
// Pop staging and refill arbiter
// Each logical FIFO owns a one-entry staging register that drives its
// ready/valid pop port. A round-robin arbiter picks at most one FIFO per
// cycle to refill from the shared store, and the drained store address
// goes back to the free list at the same edge.
module popStager
  import multiFifoPkg::*;
(
  input  logic                clk,
  input  logic                rst,

  // List status from the list controller
  input  logic [NumFifos-1:0] listNonEmpty,
  input  addrT [NumFifos-1:0] listHead,

  // Remove request back to the list controller
  output logic                removeValid,
  output fifoIdT              removeFifoId,

  // Data store read port
  output addrT                dataRdAddr,
  input  dataT                dataRdData,

  // Freed address for the free list and the credit counter
  output logic                deallocValid,
  output addrT                deallocAddr,

  // Pop ports, one per logical FIFO
  output logic [NumFifos-1:0] popValid,
  input  logic [NumFifos-1:0] popReady,
  output dataT [NumFifos-1:0] popData,
  output logic [NumFifos-1:0] popEmpty
);

  // Staging registers
  logic [NumFifos-1:0] stageValid;
  dataT [NumFifos-1:0] stageData;

  // Arbitration state
  fifoIdT              rrPtr;
  fifoIdT              candidate;
  fifoIdT              grantId;
  logic                grantFound;
  logic [NumFifos-1:0] eligible;
  logic [NumFifos-1:0] popFire;

  // A FIFO can take a refill when its stage is free or drains this cycle
  assign popFire  = stageValid & popReady;
  assign eligible = listNonEmpty & (~stageValid | popReady);

  // Search from the round-robin pointer upward, wrapping around
  always_comb begin
    grantFound = 1'b0;
    grantId    = rrPtr;
    candidate  = rrPtr;
    for (int k = 0; k < NumFifos; k++) begin
      candidate = rrPtr + fifoIdT'(k);
      if (!grantFound && eligible[candidate]) begin
        grantFound = 1'b1;
        grantId    = candidate;
      end
    end
  end

  assign removeValid  = grantFound;
  assign removeFifoId = grantId;

  // The winner's head address feeds the data store and the free list
  assign dataRdAddr   = listHead[grantId];
  assign deallocValid = grantFound;
  assign deallocAddr  = listHead[grantId];

  // The FIFO after the winner gets first pick next time
  always_ff @(posedge clk) begin
    if (rst) begin
      rrPtr      <= '0;
      stageValid <= '0;
    end else begin
      if (grantFound) begin
        rrPtr <= grantId + fifoIdT'(1);
      end
      for (int i = 0; i < NumFifos; i++) begin
        if (grantFound && grantId == fifoIdT'(i)) begin
          stageValid[i] <= 1'b1;
        end else if (popFire[i]) begin
          stageValid[i] <= 1'b0;
        end
      end
    end
  end

  // Payload only loads on a refill of that FIFO
  always_ff @(posedge clk) begin
    for (int i = 0; i < NumFifos; i++) begin
      if (grantFound && grantId == fifoIdT'(i)) begin
        stageData[i] <= dataRdData;
      end
    end
  end

  assign popValid = stageValid;
  assign popData  = stageData;

  // Empty means nothing staged and nothing waiting in the store
  assign popEmpty = ~stageValid & ~listNonEmpty;

endmodule : popStager

// File: hdl/listCtrl.sv
// Linked list controller
// Keeps head, tail and occupancy for each logical FIFO. A push appends
// its store address to the list of its FIFO by linking it behind the old
// tail in the pointer store. A refill removes the head and follows the
// link to find the next head.
module listCtrl
  import multiFifoPkg::*;
(
  input  logic                  clk,
  input  logic                  rst,

  // Append side, driven by the push interface and the free list
  input  logic                  pushValid,
  input  fifoIdT                pushFifoId,
  input  addrT                  allocAddr,

  // Remove side, driven by the refill arbiter
  input  logic                  removeValid,
  input  fifoIdT                removeFifoId,

  // List status for the refill arbiter
  output logic [NumFifos-1:0]   listNonEmpty,
  output addrT [NumFifos-1:0]   listHead,

  // Pointer store access
  output logic                  ptrWrValid,
  output addrT                  ptrWrAddr,
  output addrT                  ptrWrData,
  output addrT                  ptrRdAddr,
  input  addrT                  ptrRdData
);

  // Per-FIFO list state
  addrT  headAddr  [NumFifos];
  addrT  tailAddr  [NumFifos];
  countT listCount [NumFifos];

  // Decoded append and remove strobes, one bit per FIFO
  logic [NumFifos-1:0] appendHit;
  logic [NumFifos-1:0] removeHit;

  always_comb begin
    for (int i = 0; i < NumFifos; i++) begin
      appendHit[i]    = pushValid && (pushFifoId == fifoIdT'(i));
      removeHit[i]    = removeValid && (removeFifoId == fifoIdT'(i));
      listNonEmpty[i] = listCount[i] != '0;
      listHead[i]     = headAddr[i];
    end
  end

  // Link the new entry behind the old tail, only when there is a tail
  assign ptrWrValid = pushValid && (listCount[pushFifoId] != '0);
  assign ptrWrAddr  = tailAddr[pushFifoId];
  assign ptrWrData  = allocAddr;

  // The link of the head being removed names the next head
  assign ptrRdAddr  = headAddr[removeFifoId];

  // Occupancy is the only state that must be valid out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NumFifos; i++) begin
        listCount[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NumFifos; i++) begin
        listCount[i] <= listCount[i] + countT'(appendHit[i]) - countT'(removeHit[i]);
      end
    end
  end

  // Head and tail only carry meaning while the count is non-zero
  always_ff @(posedge clk) begin
    for (int i = 0; i < NumFifos; i++) begin
      if (appendHit[i]) begin
        tailAddr[i] <= allocAddr;
      end
      if (removeHit[i]) begin
        // Removing the last entry while a new one arrives hands the new
        // entry straight over as the head, since its link is not written
        if (listCount[i] == countT'(1) && appendHit[i]) begin
          headAddr[i] <= allocAddr;
        end else begin
          headAddr[i] <= ptrRdData;
        end
      end else if (appendHit[i] && listCount[i] == '0) begin
        headAddr[i] <= allocAddr;
      end
    end
  end

  // The arbiter must only pick lists that hold an entry
  assert property (@(posedge clk) disable iff (rst)
    removeValid |-> listCount[removeFifoId] != '0);

endmodule : listCtrl

// File: hdl/creditReturn.sv
// Push credit return
// Receiver side of the valid/credit push interface. Keeps the number of
// credits owed to the sender, starting at Depth after reset, and sends
// them back one per cycle while the stall input is low.
module creditReturn
  import multiFifoPkg::*;
(
  input  logic clk,
  input  logic rst,

  // One pulse per entry freed in the shared store
  input  logic deallocValid,

  // Sender side of the credit loop
  input  logic pushCreditStall,
  output logic pushCredit,
  output logic pushReceiverInReset
);

  // Credits owed to the sender and not yet returned
  countT owedCount;

  // Freed entries are counted one cycle late, which keeps the credit
  // from rising in the same cycle as the refill
  logic  deallocSeen;

  // A credit goes out whenever one is owed, unless stalled or the sender
  // may still be ignoring credits because we were just in reset
  assign pushCredit = (owedCount != '0) && !pushCreditStall && !pushReceiverInReset;

  always_ff @(posedge clk) begin
    if (rst) begin
      owedCount           <= countT'(Depth);
      deallocSeen         <= 1'b0;
      pushReceiverInReset <= 1'b1;
    end else begin
      owedCount           <= owedCount + countT'(deallocSeen) - countT'(pushCredit);
      deallocSeen         <= deallocValid;
      pushReceiverInReset <= 1'b0;
    end
  end

  // Sender credits, owed credits and occupied entries always add up to
  // Depth, so the owed count cannot pass it
  assert property (@(posedge clk) disable iff (rst) owedCount <= countT'(Depth));

endmodule : creditReturn

// File: hdl/freeList.sv
// Free address list
// Circular buffer of store addresses that are not held by any logical
// FIFO. Reset fills it with every address. A push takes the address at
// the head, and a refill gives the drained address back at the tail.
module freeList
  import multiFifoPkg::*;
(
  input  logic clk,
  input  logic rst,

  // Allocation, the head address is consumed on allocValid
  input  logic allocValid,
  output addrT allocAddr,

  // Deallocation, the address is appended at the tail
  input  logic deallocValid,
  input  addrT deallocAddr
);

  // Address buffer and its pointers
  addrT  addrBuf [Depth];
  addrT  rdPtr;
  addrT  wrPtr;

  // Number of free addresses currently held
  countT freeCount;

  // The next address to hand out is always at the read pointer
  assign allocAddr = addrBuf[rdPtr];

  // Pointers wrap naturally because Depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      // Every address starts out free, in ascending order
      for (int i = 0; i < Depth; i++) begin
        addrBuf[i] <= addrT'(i);
      end
      rdPtr     <= '0;
      wrPtr     <= '0;
      freeCount <= countT'(Depth);
    end else begin
      if (allocValid) begin
        rdPtr <= rdPtr + addrT'(1);
      end
      if (deallocValid) begin
        addrBuf[wrPtr] <= deallocAddr;
        wrPtr          <= wrPtr + addrT'(1);
      end
      freeCount <= freeCount + countT'(deallocValid) - countT'(allocValid);
    end
  end

  // The sender never holds more credits than free entries, so a push
  // always finds an address here
  assert property (@(posedge clk) disable iff (rst) allocValid |-> freeCount != '0);

  // Only addresses that were handed out can come back
  assert property (@(posedge clk) disable iff (rst)
    deallocValid |-> freeCount != countT'(Depth));

endmodule : freeList

// File: hdl/flopRam.sv
// Flop RAM
// Depth words of flops with one write port and one combinational read
// port. The stored word type is chosen by a type parameter, so the same
// block holds both the payload store and the link store.
module flopRam
  import multiFifoPkg::*;
#(
  // Word type held in each entry
  parameter type payloadT = dataT
) (
  input  logic    clk,

  // Write port, takes effect at the clock edge
  input  logic    wrValid,
  input  addrT    wrAddr,
  input  payloadT wrData,

  // Read port, data follows the address in the same cycle
  input  addrT    rdAddr,
  output payloadT rdData
);

  // Storage array, one word per store address
  payloadT mem [Depth];

  // A write lands at the edge and is visible to reads in the next cycle
  always_ff @(posedge clk) begin
    if (wrValid) begin
      mem[wrAddr] <= wrData;
    end
  end

  // Zero-latency read, the address decode is a plain mux
  assign rdData = mem[rdAddr];

endmodule : flopRam

// File: hdl/multiFifoPkg.sv
// Shared multi-FIFO package
// Sizes and payload types used by every block of the shared multi-FIFO
// and by its testbench. Four logical FIFOs share one flop-based store.
package multiFifoPkg;

  // Number of logical FIFOs that share the store
  localparam int NumFifos = 4;

  // Number of entries in the shared data store
  localparam int Depth = 16;

  // Width of one payload word
  localparam int DataWidth = 16;

  // Address width of the shared store, log2 of Depth
  localparam int AddrWidth = 4;

  // Width of a logical FIFO index, log2 of NumFifos
  localparam int FifoIdWidth = 2;

  // Counts must reach Depth itself, so one bit wider than an address
  localparam int CountWidth = 5;

  // One payload word as pushed and popped
  typedef logic [DataWidth-1:0] dataT;

  // An address into the data store or the pointer store
  typedef logic [AddrWidth-1:0] addrT;

  // Index of a logical FIFO
  typedef logic [FifoIdWidth-1:0] fifoIdT;

  // Occupancy or credit count, 0 up to Depth
  typedef logic [CountWidth-1:0] countT;

endpackage : multiFifoPkg
